//--- logic/cxl_mem_pkg.sv
`default_nettype none

package cxl_mem_pkg;

    // ----------------------------------------
    // AXI field widths
    // ----------------------------------------

    // Byte address as seen on AR and AW
    localparam int ADDR_W = 64;

    // Transaction ID, shared by read and write
    localparam int ID_W = 16;

    // One 64-byte memory line
    localparam int LINE_W = 512;

    // ----------------------------------------
    // Bank geometry and address split
    // ----------------------------------------

    // Byte offset within a line, dropped on decode
    localparam int OFFSET_W = 6;

    localparam int NUM_BANKS = 4;

    // Low bits of the line index pick the bank
    localparam int BANK_SEL_W = 2;

    // Next bits pick the row, anything above aliases
    localparam int ROW_W = 6;

    localparam int BANK_DEPTH = 64;

endpackage

`default_nettype wire

//--- logic/line_req_if.sv
`default_nettype none

interface line_req_if;
    import cxl_mem_pkg::*;

    // Single-cycle strobe, the bank never stalls
    logic                 req_valid;
    logic                 req_write;
    logic [ROW_W-1:0]     req_row;
    logic [ID_W-1:0]      req_id;
    logic [LINE_W-1:0]    req_wdata;

    modport source (
        output req_valid,
        output req_write,
        output req_row,
        output req_id,
        output req_wdata
    );

    modport sink (
        input req_valid,
        input req_write,
        input req_row,
        input req_id,
        input req_wdata
    );

endinterface

`default_nettype wire

//--- logic/line_rsp_if.sv
`default_nettype none

interface line_rsp_if;
    import cxl_mem_pkg::*;

    // Strobed one cycle after the matching request
    logic                 rsp_valid;
    logic                 rsp_write;
    logic [ID_W-1:0]      rsp_id;
    // Only meaningful for reads
    logic [LINE_W-1:0]    rsp_rdata;

    modport source (
        output rsp_valid,
        output rsp_write,
        output rsp_id,
        output rsp_rdata
    );

    modport sink (
        input rsp_valid,
        input rsp_write,
        input rsp_id,
        input rsp_rdata
    );

endinterface

`default_nettype wire

//--- logic/axi_req_decoder.sv
`default_nettype none

module axi_req_decoder (
    input  logic                                clk,
    input  logic                                rst_n,
    // AR channel
    input  logic [cxl_mem_pkg::ID_W-1:0]        arid_i,
    input  logic [cxl_mem_pkg::ADDR_W-1:0]      araddr_i,
    input  logic                                arvalid_i,
    output logic                                arready_o,
    // AW channel
    input  logic [cxl_mem_pkg::ID_W-1:0]        awid_i,
    input  logic [cxl_mem_pkg::ADDR_W-1:0]      awaddr_i,
    input  logic                                awvalid_i,
    output logic                                awready_o,
    // W channel
    input  logic [cxl_mem_pkg::LINE_W-1:0]      wdata_i,
    input  logic                                wvalid_i,
    output logic                                wready_o,
    // Response handshake finished
    input  logic                                done_i,
    line_req_if.source                          req [cxl_mem_pkg::NUM_BANKS]
);
    import cxl_mem_pkg::*;

    typedef enum logic {
        s_idle,
        s_busy
    } state_t;

    state_t                 state_q;
    logic                   issue_q;
    logic [BANK_SEL_W-1:0]  bank_q;
    logic [ROW_W-1:0]       row_q;
    logic                   write_q;
    logic [ID_W-1:0]        id_q;
    logic [LINE_W-1:0]      wdata_q;

    logic                   idle;
    logic                   wr_present;
    logic                   wr_accept;
    logic                   rd_accept;
    logic [ADDR_W-1:0]      sel_addr;

    // ----------------------------------------
    // Acceptance, write wins over read
    // ----------------------------------------
    assign idle       = (state_q == s_idle);
    assign wr_present = awvalid_i && wvalid_i;
    assign wr_accept  = idle && wr_present;
    assign rd_accept  = idle && arvalid_i && !wr_present;

    assign awready_o = wr_accept;
    assign wready_o  = wr_accept;
    assign arready_o = idle && !wr_present;

    assign sel_addr = wr_accept ? awaddr_i : araddr_i;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state_q <= s_idle;
            issue_q <= 1'b0;
        end else begin
            // Bank strobe lands in the cycle after acceptance
            issue_q <= wr_accept || rd_accept;
            case (state_q)
                s_idle: begin
                    if (wr_accept || rd_accept) begin
                        state_q <= s_busy;
                    end
                end
                s_busy: begin
                    if (done_i) begin
                        state_q <= s_idle;
                    end
                end
                default: state_q <= s_idle;
            endcase
        end
    end

    // Line index split: bank in the low bits, row above
    always_ff @(posedge clk) begin
        if (wr_accept || rd_accept) begin
            bank_q  <= sel_addr[OFFSET_W +: BANK_SEL_W];
            row_q   <= sel_addr[OFFSET_W + BANK_SEL_W +: ROW_W];
            write_q <= wr_accept;
            id_q    <= wr_accept ? awid_i : arid_i;
            wdata_q <= wdata_i;
        end
    end

    // ----------------------------------------
    // Bank request fan-out
    // ----------------------------------------
    for (genvar b = 0; b < NUM_BANKS; b++) begin : g_req
        assign req[b].req_valid = issue_q && (bank_q == BANK_SEL_W'(b));
        assign req[b].req_write = write_q;
        assign req[b].req_row   = row_q;
        assign req[b].req_id    = id_q;
        assign req[b].req_wdata = wdata_q;
    end

endmodule

`default_nettype wire

//--- logic/line_bank.sv
`default_nettype none

module line_bank (
    input  logic        clk,
    input  logic        rst_n,
    line_req_if.sink    req,
    line_rsp_if.source  rsp
);
    import cxl_mem_pkg::*;

    logic [LINE_W-1:0]  mem [BANK_DEPTH];

    logic               rsp_valid_q;
    logic               rsp_write_q;
    logic [ID_W-1:0]    rsp_id_q;
    logic [LINE_W-1:0]  rdata_q;

    // ----------------------------------------
    // Storage
    // ----------------------------------------
    always_ff @(posedge clk) begin
        if (req.req_valid && req.req_write) begin
            mem[req.req_row] <= req.req_wdata;
        end
    end

    // Registered read, old contents on a write
    always_ff @(posedge clk) begin
        if (req.req_valid) begin
            rdata_q     <= mem[req.req_row];
            rsp_id_q    <= req.req_id;
            rsp_write_q <= req.req_write;
        end
    end

    // ----------------------------------------
    // Response strobe, one cycle behind
    // ----------------------------------------
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            rsp_valid_q <= 1'b0;
        end else begin
            rsp_valid_q <= req.req_valid;
        end
    end

    assign rsp.rsp_valid = rsp_valid_q;
    assign rsp.rsp_write = rsp_write_q;
    assign rsp.rsp_id    = rsp_id_q;
    assign rsp.rsp_rdata = rdata_q;

endmodule

`default_nettype wire

//--- logic/axi_resp_unit.sv
`default_nettype none

module axi_resp_unit (
    input  logic                            clk,
    input  logic                            rst_n,
    line_rsp_if.sink                        rsp [cxl_mem_pkg::NUM_BANKS],
    // R channel
    output logic [cxl_mem_pkg::ID_W-1:0]    rid_o,
    output logic [cxl_mem_pkg::LINE_W-1:0]  rdata_o,
    output logic                            rvalid_o,
    input  logic                            rready_i,
    // B channel
    output logic [cxl_mem_pkg::ID_W-1:0]    bid_o,
    output logic                            bvalid_o,
    input  logic                            bready_i,
    output logic                            done_o
);
    import cxl_mem_pkg::*;

    logic [NUM_BANKS-1:0]   bank_hit;
    logic [NUM_BANKS-1:0]   bank_write;
    logic [ID_W-1:0]        bank_id [NUM_BANKS];
    logic [LINE_W-1:0]      bank_rdata [NUM_BANKS];

    logic                   sel_write;
    logic [ID_W-1:0]        sel_id;
    logic [LINE_W-1:0]      sel_rdata;

    logic                   rvalid_q;
    logic                   bvalid_q;
    logic [ID_W-1:0]        id_q;
    logic [LINE_W-1:0]      rdata_q;
    logic                   r_done;
    logic                   b_done;

    for (genvar b = 0; b < NUM_BANKS; b++) begin : g_rsp
        assign bank_hit[b]   = rsp[b].rsp_valid;
        assign bank_write[b] = rsp[b].rsp_write;
        assign bank_id[b]    = rsp[b].rsp_id;
        assign bank_rdata[b] = rsp[b].rsp_rdata;
    end

    // At most one bank answers, only one transaction is in flight
    always_comb begin
        sel_write = 1'b0;
        sel_id    = '0;
        sel_rdata = '0;
        for (int b = 0; b < NUM_BANKS; b++) begin
            if (bank_hit[b]) begin
                sel_write = bank_write[b];
                sel_id    = bank_id[b];
                sel_rdata = bank_rdata[b];
            end
        end
    end

    // ----------------------------------------
    // Hold registers and valid tracking
    // ----------------------------------------
    always_ff @(posedge clk) begin
        if (|bank_hit) begin
            id_q    <= sel_id;
            rdata_q <= sel_rdata;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            rvalid_q <= 1'b0;
            bvalid_q <= 1'b0;
        end else if (|bank_hit) begin
            rvalid_q <= !sel_write;
            bvalid_q <= sel_write;
        end else begin
            if (r_done) begin
                rvalid_q <= 1'b0;
            end
            if (b_done) begin
                bvalid_q <= 1'b0;
            end
        end
    end

    assign r_done = rvalid_q && rready_i;
    assign b_done = bvalid_q && bready_i;
    assign done_o = r_done || b_done;

    assign rid_o    = id_q;
    assign rdata_o  = rdata_q;
    assign rvalid_o = rvalid_q;
    assign bid_o    = id_q;
    assign bvalid_o = bvalid_q;

endmodule

`default_nettype wire

//--- logic/cxl_mem_slave.sv
`default_nettype none

module cxl_mem_slave (
    input  logic                                clk,
    input  logic                                rst_n,
    // AR channel
    input  logic [cxl_mem_pkg::ID_W-1:0]        arid_i,
    input  logic [cxl_mem_pkg::ADDR_W-1:0]      araddr_i,
    input  logic                                arvalid_i,
    output logic                                arready_o,
    // R channel
    output logic [cxl_mem_pkg::ID_W-1:0]        rid_o,
    output logic [cxl_mem_pkg::LINE_W-1:0]      rdata_o,
    output logic                                rvalid_o,
    input  logic                                rready_i,
    // AW channel
    input  logic [cxl_mem_pkg::ID_W-1:0]        awid_i,
    input  logic [cxl_mem_pkg::ADDR_W-1:0]      awaddr_i,
    input  logic                                awvalid_i,
    output logic                                awready_o,
    // W channel, write ID is taken from AW
    input  logic [cxl_mem_pkg::ID_W-1:0]        wid_i,
    input  logic [cxl_mem_pkg::LINE_W-1:0]      wdata_i,
    input  logic                                wvalid_i,
    output logic                                wready_o,
    // B channel
    output logic [cxl_mem_pkg::ID_W-1:0]        bid_o,
    output logic                                bvalid_o,
    input  logic                                bready_i
);
    import cxl_mem_pkg::*;

    logic done;

    line_req_if req_bus [NUM_BANKS] ();
    line_rsp_if rsp_bus [NUM_BANKS] ();

    // ----------------------------------------
    // Front end
    // ----------------------------------------
    axi_req_decoder u_decoder (
        .clk       (clk),
        .rst_n     (rst_n),
        .arid_i    (arid_i),
        .araddr_i  (araddr_i),
        .arvalid_i (arvalid_i),
        .arready_o (arready_o),
        .awid_i    (awid_i),
        .awaddr_i  (awaddr_i),
        .awvalid_i (awvalid_i),
        .awready_o (awready_o),
        .wdata_i   (wdata_i),
        .wvalid_i  (wvalid_i),
        .wready_o  (wready_o),
        .done_i    (done),
        .req       (req_bus)
    );

    // Line storage, interleaved on the low line bits
    for (genvar b = 0; b < NUM_BANKS; b++) begin : g_bank
        line_bank u_bank (
            .clk   (clk),
            .rst_n (rst_n),
            .req   (req_bus[b]),
            .rsp   (rsp_bus[b])
        );
    end

    // ----------------------------------------
    // Response side
    // ----------------------------------------
    axi_resp_unit u_resp (
        .clk      (clk),
        .rst_n    (rst_n),
        .rsp      (rsp_bus),
        .rid_o    (rid_o),
        .rdata_o  (rdata_o),
        .rvalid_o (rvalid_o),
        .rready_i (rready_i),
        .bid_o    (bid_o),
        .bvalid_o (bvalid_o),
        .bready_i (bready_i),
        .done_o   (done)
    );

endmodule

`default_nettype wire

//--- tests/cxl_mem_slave_chk.sv
`default_nettype none

module cxl_mem_slave_chk (
    input  logic                            clk,
    input  logic                            rst_n,
    input  logic                            rvalid_i,
    input  logic                            rready_i,
    input  logic [cxl_mem_pkg::ID_W-1:0]    rid_i,
    input  logic [cxl_mem_pkg::LINE_W-1:0]  rdata_i,
    input  logic                            bvalid_i,
    input  logic                            bready_i,
    input  logic [cxl_mem_pkg::ID_W-1:0]    bid_i,
    input  logic                            awready_i,
    input  logic                            wready_i
);

    // ----------------------------------------
    // Response channels hold until accepted
    // ----------------------------------------
    a_r_hold: assert property (@(posedge clk) disable iff (!rst_n)
        rvalid_i && !rready_i |=> rvalid_i && $stable(rdata_i) && $stable(rid_i))
        else $error("R valid dropped or payload changed while stalled");

    a_b_hold: assert property (@(posedge clk) disable iff (!rst_n)
        bvalid_i && !bready_i |=> bvalid_i && $stable(bid_i))
        else $error("B valid dropped or ID changed while stalled");

    // Only one transaction in flight
    a_rb_excl: assert property (@(posedge clk) disable iff (!rst_n)
        !(rvalid_i && bvalid_i))
        else $error("R and B valid high in the same cycle");

    // AW and W are accepted as a pair
    a_aw_w: assert property (@(posedge clk) disable iff (!rst_n)
        awready_i == wready_i)
        else $error("awready and wready differ");

endmodule

`default_nettype wire

//--- tests/cxl_mem_slave_tb.sv
`default_nettype none

module cxl_mem_slave_tb;
    import cxl_mem_pkg::*;

    localparam int NUM_TXN     = 32 * 2 + 2 + 8 * 2 + 2;
    localparam int CYCLE_LIMIT = 20 * NUM_TXN + 100;

    logic clk = 1'b0;
    logic rst_n;
    logic [ID_W-1:0]   arid_i, rid_o, awid_i, wid_i, bid_o;
    logic [ADDR_W-1:0] araddr_i, awaddr_i;
    logic [LINE_W-1:0] rdata_o, wdata_i;
    logic arvalid_i, arready_o, rvalid_o, rready_i;
    logic awvalid_i, awready_o, wvalid_i, wready_o, bvalid_o, bready_i;

    // Reference memory keyed by {row, bank}
    logic [LINE_W-1:0] ref_mem [logic [BANK_SEL_W+ROW_W-1:0]];
    logic [ADDR_W-1:0] rd_addr_q [$];
    logic [ID_W-1:0]   rd_id_q [$];
    logic [ID_W-1:0]   bid_q [$];

    string             cur_test;
    int                err_cnt = 0;
    int                test_cnt = 0;
    int                test_err_start = 0;
    int                cycle_cnt = 0;
    logic              r_wait = 1'b0;
    logic [LINE_W-1:0] rdata_prev;
    logic [ADDR_W-1:0] t_addr [32];

    cxl_mem_slave UUT (.*);

    bind cxl_mem_slave cxl_mem_slave_chk u_chk (
        .clk       (clk),
        .rst_n     (rst_n),
        .rvalid_i  (rvalid_o),
        .rready_i  (rready_i),
        .rid_i     (rid_o),
        .rdata_i   (rdata_o),
        .bvalid_i  (bvalid_o),
        .bready_i  (bready_i),
        .bid_i     (bid_o),
        .awready_i (awready_o),
        .wready_i  (wready_o)
    );

    always #5 clk = ~clk;

    // Addresses alias every 16 KiB, offset bits dropped
    function automatic logic [LINE_W-1:0] expected_line(input logic [ADDR_W-1:0] addr);
        logic [BANK_SEL_W+ROW_W-1:0] key;
        key = addr[OFFSET_W +: BANK_SEL_W + ROW_W];
        if (ref_mem.exists(key)) begin
            return ref_mem[key];
        end
        return 'x;
    endfunction

    function automatic logic [LINE_W-1:0] random_line();
        logic [LINE_W-1:0] v;
        for (int k = 0; k < LINE_W / 32; k++) begin
            v[k*32 +: 32] = $urandom;
        end
        return v;
    endfunction

    // ----------------------------------------
    // Comparing process
    // ----------------------------------------
    always @(posedge clk) begin : compare
        logic [ADDR_W-1:0] a;
        logic [ID_W-1:0]   id;
        if (rst_n) begin
            if (awvalid_i && awready_o) begin
                ref_mem[awaddr_i[OFFSET_W +: BANK_SEL_W + ROW_W]] = wdata_i;
                bid_q.push_back(awid_i);
            end else if (arvalid_i && arready_o) begin
                rd_addr_q.push_back(araddr_i);
                rd_id_q.push_back(arid_i);
            end
            if (bvalid_o && bready_i) begin
                if (bid_q.size() == 0) begin
                    $display("%s: B response with no write outstanding", cur_test);
                    err_cnt++;
                end else begin
                    id = bid_q.pop_front();
                    if (bid_o !== id) begin
                        $display("error %s: bid expected %h actual %h", cur_test, id, bid_o);
                        err_cnt++;
                    end
                end
            end
            if (rvalid_o && rready_i) begin
                if (rd_addr_q.size() == 0) begin
                    $display("%s: R response with no read outstanding", cur_test);
                    err_cnt++;
                end else begin
                    a  = rd_addr_q.pop_front();
                    id = rd_id_q.pop_front();
                    if (rdata_o !== expected_line(a)) begin
                        $display("error %s: rdata expected %h actual %h",
                                 cur_test, expected_line(a), rdata_o);
                        err_cnt++;
                    end
                    if (rid_o !== id) begin
                        $display("error %s: rid expected %h actual %h", cur_test, id, rid_o);
                        err_cnt++;
                    end
                end
            end
            // Same rules as the bound checker
            if (r_wait && (!rvalid_o || rdata_o !== rdata_prev)) begin
                $display("%s: R response changed before rready", cur_test);
                err_cnt++;
            end
            if ((rvalid_o && bvalid_o) || awready_o !== wready_o) begin
                $display("%s: R and B valid together or AW and W ready differ", cur_test);
                err_cnt++;
            end
            r_wait     = rvalid_o && !rready_i;
            rdata_prev = rdata_o;
        end
    end

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= CYCLE_LIMIT) begin
            $display("timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
            $display("sim failed");
            $finish;
        end
    end

    // ----------------------------------------
    // Stimulus tasks
    // ----------------------------------------
    task automatic send_write(input logic [ADDR_W-1:0] addr, input logic [ID_W-1:0] id,
                              input logic [LINE_W-1:0] data);
        @(posedge clk);
        awaddr_i  <= addr;
        awid_i    <= id;
        wid_i     <= id;
        wdata_i   <= data;
        awvalid_i <= 1'b1;
        wvalid_i  <= 1'b1;
        do @(posedge clk); while (!awready_o);
        awvalid_i <= 1'b0;
        wvalid_i  <= 1'b0;
    endtask

    task automatic send_read(input logic [ADDR_W-1:0] addr, input logic [ID_W-1:0] id);
        @(posedge clk);
        araddr_i  <= addr;
        arid_i    <= id;
        arvalid_i <= 1'b1;
        do @(posedge clk); while (!arready_o);
        arvalid_i <= 1'b0;
    endtask

    // Stall holds ready low for that many cycles once valid is up
    task automatic wait_resp(input bit is_write, input int stall);
        if (is_write) begin
            bready_i <= (stall == 0);
        end else begin
            rready_i <= (stall == 0);
        end
        do @(posedge clk); while (!(is_write ? bvalid_o : rvalid_o));
        // A read stall keeps a write waiting on AW and W
        if (!is_write && stall > 0) begin
            awvalid_i <= 1'b1;
            wvalid_i  <= 1'b1;
        end
        repeat (stall) begin
            @(posedge clk);
            if (!(is_write ? bvalid_o : rvalid_o) || arready_o || awready_o) begin
                $display("%s: response dropped or request accepted while stalled", cur_test);
                err_cnt++;
            end
        end
        if (stall > 0) begin
            awvalid_i <= 1'b0;
            wvalid_i  <= 1'b0;
            if (is_write) begin
                bready_i <= 1'b1;
            end else begin
                rready_i <= 1'b1;
            end
            @(posedge clk);
        end
    endtask

    task automatic start_test(input string name);
        cur_test       = name;
        test_err_start = err_cnt;
    endtask

    task automatic report_test();
        @(posedge clk);
        test_cnt++;
        if (err_cnt == test_err_start) begin
            $display("test %s: ok", cur_test);
        end else begin
            $display("test %s: %0d errors", cur_test, err_cnt - test_err_start);
        end
    endtask

    // ----------------------------------------
    // Test sequence
    // ----------------------------------------
    initial begin : main
        logic [ADDR_W-1:0] addr;
        logic [LINE_W-1:0] data;
        int                stall;
        void'($urandom(32'hc2bfebef));
        rst_n     = 1'b0;
        arid_i    = '0;
        araddr_i  = '0;
        arvalid_i = 1'b0;
        rready_i  = 1'b0;
        awid_i    = '0;
        awaddr_i  = '0;
        awvalid_i = 1'b0;
        wid_i     = '0;
        wdata_i   = '0;
        wvalid_i  = 1'b0;
        bready_i  = 1'b0;
        repeat (2) @(posedge clk);
        rst_n <= 1'b1;

        start_test("reset_state");
        @(posedge clk);
        if (rvalid_o || bvalid_o || !arready_o) begin
            $display("%s: valid outputs not low or arready not high after reset", cur_test);
            err_cnt++;
        end
        report_test();

        start_test("write_read_back");
        for (int i = 0; i < 32; i++) begin
            t_addr[i]      = {$urandom, $urandom};
            t_addr[i][7:6] = 2'(i);
            send_write(t_addr[i], 16'($urandom), random_line());
            wait_resp(1'b1, 0);
        end
        for (int i = 0; i < 32; i++) begin
            send_read(t_addr[i], 16'($urandom));
            wait_resp(1'b0, 0);
        end
        report_test();

        start_test("aliasing");
        addr = {$urandom, $urandom};
        send_write(addr, 16'($urandom), random_line());
        wait_resp(1'b1, 0);
        send_read(addr + 64'h4000, 16'($urandom));
        wait_resp(1'b0, 0);
        report_test();

        start_test("back_pressure");
        for (int i = 0; i < 8; i++) begin
            addr  = {$urandom, $urandom};
            stall = $urandom_range(8, 1);
            send_write(addr, 16'($urandom), random_line());
            wait_resp(1'b1, stall);
            stall = $urandom_range(8, 1);
            send_read(addr, 16'($urandom));
            wait_resp(1'b0, stall);
        end
        report_test();

        // AR and AW+W presented in the same cycle to one line
        start_test("write_priority");
        addr = {$urandom, $urandom};
        data = random_line();
        @(posedge clk);
        araddr_i  <= addr;
        arid_i    <= 16'h00a1;
        arvalid_i <= 1'b1;
        awaddr_i  <= addr;
        awid_i    <= 16'h00b2;
        wid_i     <= 16'h00b2;
        wdata_i   <= data;
        awvalid_i <= 1'b1;
        wvalid_i  <= 1'b1;
        do @(posedge clk); while (!awready_o);
        if (arready_o || rd_addr_q.size() != 0) begin
            $display("%s: read accepted before the competing write", cur_test);
            err_cnt++;
        end
        awvalid_i <= 1'b0;
        wvalid_i  <= 1'b0;
        wait_resp(1'b1, 0);
        do @(posedge clk); while (!arready_o);
        arvalid_i <= 1'b0;
        wait_resp(1'b0, 0);
        report_test();

        if (rd_addr_q.size() != 0 || bid_q.size() != 0) begin
            $display("responses missing at end of run");
            err_cnt++;
        end
        $display("tests run: %0d, errors: %0d", test_cnt, err_cnt);
        if (err_cnt == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- verilog.f
logic/cxl_mem_pkg.sv
logic/line_req_if.sv
logic/line_rsp_if.sv
logic/axi_req_decoder.sv
logic/line_bank.sv
logic/axi_resp_unit.sv
logic/cxl_mem_slave.sv
tests/cxl_mem_slave_chk.sv
tests/cxl_mem_slave_tb.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= cxl_mem_slave_tb
FILELIST  ?= verilog.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0
SIM_ARGS  ?= +verilator+error+limit+100

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)
	-./$(BUILD_DIR)/V$(TOP) $(SIM_ARGS) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "sim failed" $(LOG); then exit 1; fi
	@grep -q "sim passed" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
